//--- common/axil_xbar_cfg.svh
// Crossbar configuration macros (port counts, widths, address map, FIFO depths), include where needed
`ifndef AXIL_XBAR_CFG_SVH
`define AXIL_XBAR_CFG_SVH

// Manager and subordinate port counts
`define XBAR_S_COUNT 2
`define XBAR_M_COUNT 2

// Bus widths
`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32

// Address map, one window per subordinate
`define XBAR_SUB0_BASE 32'h0000_0000
`define XBAR_SUB0_ADDR_W 16
`define XBAR_SUB1_BASE 32'h0001_0000
`define XBAR_SUB1_ADDR_W 16

// Subordinate 1 only accepts secure reads
`define XBAR_SUB_SECURE 2'b10

// Routing FIFO depths
`define XBAR_ACCEPT_DEPTH 8
`define XBAR_ISSUE_DEPTH 8

`endif

//--- common/axil_xbar_pkg.sv
// Shared address, data, response and payload types for the read crossbar RTL and its testbench
`include "axil_xbar_cfg.svh"

package axil_xbar_pkg;

    typedef logic [`XBAR_ADDR_W-1:0] addr_t;
    typedef logic [`XBAR_DATA_W-1:0] data_t;

    // 0 is OKAY, 3 is DECERR
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // AR channel payload, 35 bits
    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } ar_payload_t;

    // R channel payload, 34 bits
    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_payload_t;

endpackage

//--- common/axil_rd_if.sv
// AXI4-Lite read channel bundle used between the crossbar core and its register slices
`timescale 1ns/1ps

interface axil_rd_if;

    axil_xbar_pkg::addr_t araddr;
    logic [2:0]           arprot;
    logic                 arvalid;
    logic                 arready;

    axil_xbar_pkg::data_t rdata;
    axil_xbar_pkg::resp_t rresp;
    logic                 rvalid;
    logic                 rready;

    // Side that issues reads
    modport mgr (
        output araddr, arprot, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    // Side that answers reads
    modport sub (
        input  araddr, arprot, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

endinterface

//--- hw/axil_skid_reg.sv
// Two-entry valid/ready skid buffer with registered ready, placed on AR and R paths of the crossbar
`timescale 1ns/1ps

module axil_skid_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t out_data_reg;
    payload_t skid_data_reg;
    logic     out_valid_reg;
    logic     skid_valid_reg;
    logic     in_ready_reg;

    always_ff @(posedge clk) begin
        if (!out_valid_reg || out_ready) begin
            // Output slot frees up, refill from skid first
            if (skid_valid_reg) begin
                out_data_reg <= skid_data_reg;
                out_valid_reg <= 1'b1;
                skid_valid_reg <= 1'b0;
            end else begin
                out_data_reg <= in_data;
                out_valid_reg <= in_valid && in_ready_reg;
            end
            in_ready_reg <= 1'b1;
        end else if (in_valid && in_ready_reg) begin
            // Output stalled, park the item and close the input
            skid_data_reg <= in_data;
            skid_valid_reg <= 1'b1;
            in_ready_reg <= 1'b0;
        end

        if (rst) begin
            out_valid_reg <= 1'b0;
            skid_valid_reg <= 1'b0;
            in_ready_reg <= 1'b0;
        end
    end

    assign in_ready = in_ready_reg;
    assign out_valid = out_valid_reg;
    assign out_data = out_data_reg;

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data)
    );

endmodule

//--- crossbar/axil_addr_decode.sv
// Per-manager read address decode with security check, issuing a forward and a response command
`timescale 1ns/1ps
`include "axil_xbar_cfg.svh"

module axil_addr_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  axil_xbar_pkg::addr_t                araddr,
    input  logic [2:0]                          arprot,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [$clog2(`XBAR_M_COUNT)-1:0]    sel,
    output logic                                avalid,
    input  logic                                aready,
    output logic [$clog2(`XBAR_M_COUNT)-1:0]    rc_sel,
    output logic                                rc_decerr,
    output logic                                rc_valid,
    input  logic                                rc_ready
);

    localparam int SEL_W = $clog2(`XBAR_M_COUNT);
    localparam logic [`XBAR_M_COUNT-1:0] SUB_SECURE = `XBAR_SUB_SECURE;

    axil_xbar_pkg::addr_t addr_reg;
    logic [2:0]           prot_reg;
    logic                 arready_reg;
    logic                 a_pend_reg;
    logic                 rc_pend_reg;
    logic                 hit0;
    logic                 hit1;
    logic                 decerr;
    logic                 a_done;
    logic                 rc_done;

    // Window match on the upper address bits
    assign hit0 = (addr_reg >> `XBAR_SUB0_ADDR_W) == (`XBAR_SUB0_BASE >> `XBAR_SUB0_ADDR_W);
    assign hit1 = (addr_reg >> `XBAR_SUB1_ADDR_W) == (`XBAR_SUB1_BASE >> `XBAR_SUB1_ADDR_W);

    assign sel = SEL_W'(hit1);

    // arprot[1] set means non-secure
    assign decerr = !(hit0 || hit1) || (SUB_SECURE[sel] && prot_reg[1]);

    assign avalid = a_pend_reg && !decerr;
    assign rc_sel = sel;
    assign rc_decerr = decerr;
    assign rc_valid = rc_pend_reg;
    assign arready = arready_reg;

    assign a_done = !avalid || aready;
    assign rc_done = !rc_valid || rc_ready;

    always_ff @(posedge clk) begin
        if (arvalid && arready_reg) begin
            addr_reg <= araddr;
            prot_reg <= arprot;
            a_pend_reg <= 1'b1;
            rc_pend_reg <= 1'b1;
            arready_reg <= 1'b0;
        end else begin
            if (a_done) begin
                a_pend_reg <= 1'b0;
            end
            if (rc_done) begin
                rc_pend_reg <= 1'b0;
            end
            // Reopen only once both commands are gone
            if (a_done && rc_done) begin
                arready_reg <= 1'b1;
            end
        end

        if (rst) begin
            a_pend_reg <= 1'b0;
            rc_pend_reg <= 1'b0;
            arready_reg <= 1'b0;
        end
    end

    // A forward waiting for its arbiter keeps its target
    a_fwd_held: assert property (
        @(posedge clk) disable iff (rst)
        avalid && !aready |=> avalid && $stable(sel)
    );

endmodule

//--- crossbar/rr_arbiter.sv
// Round-robin arbiter over the manager ports, grant held until acknowledged
`timescale 1ns/1ps
`include "axil_xbar_cfg.svh"

module rr_arbiter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [`XBAR_S_COUNT-1:0]            req,
    input  logic [`XBAR_S_COUNT-1:0]            ack,
    output logic [`XBAR_S_COUNT-1:0]            grant,
    output logic                                grant_valid,
    output logic [$clog2(`XBAR_S_COUNT)-1:0]    grant_index
);

    localparam int PORTS = `XBAR_S_COUNT;
    localparam int IDX_W = $clog2(`XBAR_S_COUNT);

    logic [PORTS-1:0] grant_reg;
    logic             grant_valid_reg;
    logic [IDX_W-1:0] grant_index_reg;
    logic [IDX_W-1:0] last_reg;
    logic             pick_valid;
    logic [IDX_W-1:0] pick_index;

    // Search starts at the port after the last grant
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick_index = last_reg;
        for (int k = 1; k <= PORTS; k++) begin
            idx = (int'(last_reg) + k) % PORTS;
            if (!pick_valid && req[idx]) begin
                pick_valid = 1'b1;
                pick_index = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid_reg) begin
            if (|(ack & grant_reg)) begin
                grant_valid_reg <= 1'b0;
                grant_reg <= '0;
            end
        end else if (pick_valid) begin
            grant_valid_reg <= 1'b1;
            grant_reg <= '0;
            grant_reg[pick_index] <= 1'b1;
            grant_index_reg <= pick_index;
            last_reg <= pick_index;
        end

        if (rst) begin
            grant_valid_reg <= 1'b0;
            grant_reg <= '0;
            last_reg <= IDX_W'(PORTS - 1);
        end
    end

    assign grant = grant_reg;
    assign grant_valid = grant_valid_reg;
    assign grant_index = grant_index_reg;

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (rst)
        grant_valid |-> $onehot(grant)
    );

endmodule

//--- crossbar/axil_xbar_rd.sv
// Read crossbar core: decode, arbitration, AR/R muxing, routing FIFOs and decode-error responses
`timescale 1ns/1ps
`include "axil_xbar_cfg.svh"

module axil_xbar_rd (
    input  logic   clk,
    input  logic   rst,
    axil_rd_if.sub mgr [`XBAR_S_COUNT],
    axil_rd_if.mgr sub [`XBAR_M_COUNT]
);

    localparam int S_COUNT = `XBAR_S_COUNT;
    localparam int M_COUNT = `XBAR_M_COUNT;
    localparam int SEL_W = $clog2(`XBAR_M_COUNT);
    localparam int IDX_W = $clog2(`XBAR_S_COUNT);

    // Manager side to subordinate side
    axil_xbar_pkg::addr_t s_addr [S_COUNT];
    logic [2:0]           s_prot [S_COUNT];
    logic [M_COUNT-1:0]   s_avalid [S_COUNT];
    logic [M_COUNT-1:0]   s_rready [S_COUNT];

    // Subordinate side to manager side
    logic [S_COUNT-1:0]   m_aready [M_COUNT];
    axil_xbar_pkg::data_t m_rdata [M_COUNT];
    axil_xbar_pkg::resp_t m_rresp [M_COUNT];
    logic [S_COUNT-1:0]   m_rvalid [M_COUNT];

    for (genvar m = 0; m < S_COUNT; m++) begin : g_mgr
        localparam int DEPTH = `XBAR_ACCEPT_DEPTH;
        localparam int AW = $clog2(`XBAR_ACCEPT_DEPTH);

        logic [SEL_W-1:0] sel;
        logic             avalid;
        logic             aready;
        logic [SEL_W-1:0] rc_sel;
        logic             rc_decerr;
        logic             rc_valid;
        logic             rc_ready;

        // Accepted address, held until it is forwarded
        axil_xbar_pkg::addr_t addr_reg;
        logic [2:0]           prot_reg;

        // Entry is {select, decerr}
        logic [SEL_W:0]   fifo_mem [DEPTH];
        logic [AW:0]      wr_ptr_reg;
        logic [AW:0]      rd_ptr_reg;
        logic [AW:0]      fill;
        logic             half_full_reg;
        logic [SEL_W-1:0] head_sel_reg;
        logic             head_decerr_reg;
        logic             head_valid_reg;
        logic             head_pop;

        axil_addr_decode dec_i (
            .clk(clk),
            .rst(rst),
            .araddr(mgr[m].araddr),
            .arprot(mgr[m].arprot),
            .arvalid(mgr[m].arvalid),
            .arready(mgr[m].arready),
            .sel(sel),
            .avalid(avalid),
            .aready(aready),
            .rc_sel(rc_sel),
            .rc_decerr(rc_decerr),
            .rc_valid(rc_valid),
            .rc_ready(rc_ready)
        );

        assign s_addr[m] = addr_reg;
        assign s_prot[m] = prot_reg;

        always_comb begin
            s_avalid[m] = '0;
            s_avalid[m][sel] = avalid;
        end
        assign aready = m_aready[sel][m];

        // Stop taking addresses at half depth
        assign rc_ready = !half_full_reg;
        assign fill = wr_ptr_reg - rd_ptr_reg;

        always_ff @(posedge clk) begin
            if (mgr[m].arvalid && mgr[m].arready) begin
                addr_reg <= mgr[m].araddr;
                prot_reg <= mgr[m].arprot;
            end

            if (rc_valid && rc_ready) begin
                fifo_mem[wr_ptr_reg[AW-1:0]] <= {rc_sel, rc_decerr};
                wr_ptr_reg <= wr_ptr_reg + 1'b1;
            end

            if (head_pop) begin
                head_valid_reg <= 1'b0;
            end
            if ((rd_ptr_reg != wr_ptr_reg) && (!head_valid_reg || head_pop)) begin
                {head_sel_reg, head_decerr_reg} <= fifo_mem[rd_ptr_reg[AW-1:0]];
                head_valid_reg <= 1'b1;
                rd_ptr_reg <= rd_ptr_reg + 1'b1;
            end

            half_full_reg <= fill >= (AW + 1)'(DEPTH / 2);

            if (rst) begin
                wr_ptr_reg <= '0;
                rd_ptr_reg <= '0;
                head_valid_reg <= 1'b0;
                half_full_reg <= 1'b0;
            end
        end

        // Decode errors are answered here with zero data
        assign mgr[m].rdata = head_decerr_reg ? '0 : m_rdata[head_sel_reg];
        assign mgr[m].rresp = head_decerr_reg ? axil_xbar_pkg::RESP_DECERR
                                              : m_rresp[head_sel_reg];
        assign mgr[m].rvalid = head_valid_reg
                             && (head_decerr_reg || m_rvalid[head_sel_reg][m]);

        always_comb begin
            s_rready[m] = '0;
            s_rready[m][head_sel_reg] = head_valid_reg && !head_decerr_reg && mgr[m].rready;
        end

        assign head_pop = mgr[m].rvalid && mgr[m].rready;
    end

    for (genvar n = 0; n < M_COUNT; n++) begin : g_sub
        localparam int DEPTH = `XBAR_ISSUE_DEPTH;
        localparam int AW = $clog2(`XBAR_ISSUE_DEPTH);

        logic [S_COUNT-1:0] req;
        logic [S_COUNT-1:0] ack;
        logic [S_COUNT-1:0] grant;
        logic               grant_valid;
        logic [IDX_W-1:0]   grant_index;

        // Granted manager per issued read
        logic [IDX_W-1:0]   fifo_mem [DEPTH];
        logic [AW:0]        wr_ptr_reg;
        logic [AW:0]        rd_ptr_reg;
        logic [AW:0]        fill;
        logic               half_full_reg;
        logic [IDX_W-1:0]   r_sel;

        rr_arbiter arb_i (
            .clk(clk),
            .rst(rst),
            .req(req),
            .ack(ack),
            .grant(grant),
            .grant_valid(grant_valid),
            .grant_index(grant_index)
        );

        for (genvar m = 0; m < S_COUNT; m++) begin : g_req
            assign req[m] = s_avalid[m][n] && !grant_valid && !half_full_reg;
            assign ack[m] = grant[m] && sub[n].arvalid && sub[n].arready;
        end

        assign sub[n].araddr = s_addr[grant_index];
        assign sub[n].arprot = s_prot[grant_index];
        assign sub[n].arvalid = grant_valid && s_avalid[grant_index][n];

        always_comb begin
            m_aready[n] = '0;
            m_aready[n][grant_index] = grant_valid && sub[n].arready;
        end

        assign fill = wr_ptr_reg - rd_ptr_reg;

        always_ff @(posedge clk) begin
            if (sub[n].arvalid && sub[n].arready) begin
                fifo_mem[wr_ptr_reg[AW-1:0]] <= grant_index;
                wr_ptr_reg <= wr_ptr_reg + 1'b1;
            end
            if (sub[n].rvalid && sub[n].rready) begin
                rd_ptr_reg <= rd_ptr_reg + 1'b1;
            end

            half_full_reg <= fill >= (AW + 1)'(DEPTH / 2);

            if (rst) begin
                wr_ptr_reg <= '0;
                rd_ptr_reg <= '0;
                half_full_reg <= 1'b0;
            end
        end

        // Steer R back to the manager at the FIFO head
        assign r_sel = fifo_mem[rd_ptr_reg[AW-1:0]];
        assign m_rdata[n] = sub[n].rdata;
        assign m_rresp[n] = sub[n].rresp;

        always_comb begin
            m_rvalid[n] = '0;
            m_rvalid[n][r_sel] = sub[n].rvalid;
        end
        assign sub[n].rready = s_rready[r_sel][n];
    end

endmodule

//--- hw/axil_xbar_rd_top.sv
// Read crossbar top level with plain AXI4-Lite ports and skid registers on manager R and subordinate AR
`timescale 1ns/1ps
`include "axil_xbar_cfg.svh"

module axil_xbar_rd_top (
    input  logic                        clk,
    input  logic                        rst,

    // Manager ports
    input  axil_xbar_pkg::addr_t        s_araddr [`XBAR_S_COUNT],
    input  logic [2:0]                  s_arprot [`XBAR_S_COUNT],
    input  logic [`XBAR_S_COUNT-1:0]    s_arvalid,
    output logic [`XBAR_S_COUNT-1:0]    s_arready,
    output axil_xbar_pkg::data_t        s_rdata [`XBAR_S_COUNT],
    output axil_xbar_pkg::resp_t        s_rresp [`XBAR_S_COUNT],
    output logic [`XBAR_S_COUNT-1:0]    s_rvalid,
    input  logic [`XBAR_S_COUNT-1:0]    s_rready,

    // Subordinate ports
    output axil_xbar_pkg::addr_t        m_araddr [`XBAR_M_COUNT],
    output logic [2:0]                  m_arprot [`XBAR_M_COUNT],
    output logic [`XBAR_M_COUNT-1:0]    m_arvalid,
    input  logic [`XBAR_M_COUNT-1:0]    m_arready,
    input  axil_xbar_pkg::data_t        m_rdata [`XBAR_M_COUNT],
    input  axil_xbar_pkg::resp_t        m_rresp [`XBAR_M_COUNT],
    input  logic [`XBAR_M_COUNT-1:0]    m_rvalid,
    output logic [`XBAR_M_COUNT-1:0]    m_rready
);

    axil_rd_if mgr_if [`XBAR_S_COUNT] ();
    axil_rd_if sub_if [`XBAR_M_COUNT] ();

    axil_xbar_rd xbar_i (
        .clk(clk),
        .rst(rst),
        .mgr(mgr_if),
        .sub(sub_if)
    );

    for (genvar m = 0; m < `XBAR_S_COUNT; m++) begin : g_mgr
        axil_xbar_pkg::r_payload_t r_out;

        assign mgr_if[m].araddr = s_araddr[m];
        assign mgr_if[m].arprot = s_arprot[m];
        assign mgr_if[m].arvalid = s_arvalid[m];
        assign s_arready[m] = mgr_if[m].arready;

        axil_skid_reg #(
            .payload_t(axil_xbar_pkg::r_payload_t)
        ) r_reg_i (
            .clk(clk),
            .rst(rst),
            .in_valid(mgr_if[m].rvalid),
            .in_ready(mgr_if[m].rready),
            .in_data({mgr_if[m].rdata, mgr_if[m].rresp}),
            .out_valid(s_rvalid[m]),
            .out_ready(s_rready[m]),
            .out_data(r_out)
        );

        assign s_rdata[m] = r_out.data;
        assign s_rresp[m] = r_out.resp;
    end

    for (genvar n = 0; n < `XBAR_M_COUNT; n++) begin : g_sub
        axil_xbar_pkg::ar_payload_t ar_out;

        axil_skid_reg #(
            .payload_t(axil_xbar_pkg::ar_payload_t)
        ) ar_reg_i (
            .clk(clk),
            .rst(rst),
            .in_valid(sub_if[n].arvalid),
            .in_ready(sub_if[n].arready),
            .in_data({sub_if[n].araddr, sub_if[n].arprot}),
            .out_valid(m_arvalid[n]),
            .out_ready(m_arready[n]),
            .out_data(ar_out)
        );

        assign m_araddr[n] = ar_out.addr;
        assign m_arprot[n] = ar_out.prot;

        assign sub_if[n].rdata = m_rdata[n];
        assign sub_if[n].rresp = m_rresp[n];
        assign sub_if[n].rvalid = m_rvalid[n];
        assign m_rready[n] = sub_if[n].rready;
    end

endmodule

//--- test/axil_sub_model.sv
// Behavioral AXI4-Lite read subordinate for the testbench, answers in order after a fixed latency
`timescale 1ns/1ps

module axil_sub_model #(
    parameter int                   LATENCY = 2,
    parameter axil_xbar_pkg::data_t XOR_MASK = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  axil_xbar_pkg::addr_t araddr,
    input  logic [2:0]           arprot,
    input  logic                 arvalid,
    output logic                 arready,
    output axil_xbar_pkg::data_t rdata,
    output axil_xbar_pkg::resp_t rresp,
    output logic                 rvalid,
    input  logic                 rready
);

    // Accepted addresses and the cycle each one may be answered
    axil_xbar_pkg::addr_t addr_q [$];
    int                   due_q [$];
    int                   cycle = 0;
    axil_xbar_pkg::data_t rdata_reg = '0;
    logic                 rvalid_reg = 1'b0;

    assign arready = !rst;
    assign rdata = rdata_reg;
    assign rresp = axil_xbar_pkg::RESP_OKAY;
    assign rvalid = rvalid_reg;

    always @(posedge clk) begin
        if (rst) begin
            addr_q.delete();
            due_q.delete();
            cycle = 0;
            rvalid_reg <= 1'b0;
        end else begin
            cycle = cycle + 1;
            if (arvalid && arready) begin
                addr_q.push_back(araddr);
                due_q.push_back(cycle + LATENCY);
            end
            if (rvalid_reg && rready) begin
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            if (!rvalid_reg || rready) begin
                // Oldest read goes out once its latency has passed
                if (addr_q.size() != 0 && due_q[0] <= cycle) begin
                    rdata_reg <= addr_q[0] ^ XOR_MASK;
                    rvalid_reg <= 1'b1;
                end else begin
                    rvalid_reg <= 1'b0;
                end
            end
        end
    end

endmodule

//--- test/tb_axil_xbar_rd.sv
// Testbench for the read crossbar, replays the vector file from both managers and checks each response
`timescale 1ns/1ps
`include "axil_xbar_cfg.svh"

module tb_axil_xbar_rd;

    localparam int S = `XBAR_S_COUNT;
    localparam int M = `XBAR_M_COUNT;
    localparam int MAX_VEC = 64;
    localparam int FIELDS = 5;

    logic clk;
    logic rst;

    axil_xbar_pkg::addr_t s_araddr [S];
    logic [2:0]           s_arprot [S];
    logic [S-1:0]         s_arvalid;
    logic [S-1:0]         s_arready;
    axil_xbar_pkg::data_t s_rdata [S];
    axil_xbar_pkg::resp_t s_rresp [S];
    logic [S-1:0]         s_rvalid;
    logic [S-1:0]         s_rready;

    axil_xbar_pkg::addr_t m_araddr [M];
    logic [2:0]           m_arprot [M];
    logic [M-1:0]         m_arvalid;
    logic [M-1:0]         m_arready;
    axil_xbar_pkg::data_t m_rdata [M];
    axil_xbar_pkg::resp_t m_rresp [M];
    logic [M-1:0]         m_rvalid;
    logic [M-1:0]         m_rready;

    // Raw file words, five per read
    logic [31:0]          vec_mem [MAX_VEC*FIELDS];
    int                   vec_mgr [MAX_VEC];
    axil_xbar_pkg::addr_t vec_addr [MAX_VEC];
    logic [2:0]           vec_prot [MAX_VEC];
    axil_xbar_pkg::resp_t vec_resp [MAX_VEC];
    axil_xbar_pkg::data_t vec_data [MAX_VEC];
    int                   vec_count;

    int                   cycle_count;
    int                   cycle_limit;
    int                   errors;
    logic [31:0]          lfsr_state;

    // Vector indices of outstanding reads, in issue order
    int                   exp_idx_q [S][$];
    int                   resp_count [S];
    int                   resp_expected [S];
    int                   fwd_count [M];
    int                   fwd_expected [M];

    // Address still waiting for its subordinate, per manager
    logic                 pend_fwd [S];
    axil_xbar_pkg::addr_t pend_addr [S];
    logic [2:0]           pend_prot [S];
    int                   pend_port [S];
    int                   passed_by [S];

    axil_xbar_rd_top dut_i (
        .clk(clk),
        .rst(rst),
        .s_araddr(s_araddr),
        .s_arprot(s_arprot),
        .s_arvalid(s_arvalid),
        .s_arready(s_arready),
        .s_rdata(s_rdata),
        .s_rresp(s_rresp),
        .s_rvalid(s_rvalid),
        .s_rready(s_rready),
        .m_araddr(m_araddr),
        .m_arprot(m_arprot),
        .m_arvalid(m_arvalid),
        .m_arready(m_arready),
        .m_rdata(m_rdata),
        .m_rresp(m_rresp),
        .m_rvalid(m_rvalid),
        .m_rready(m_rready)
    );

    axil_sub_model #(
        .LATENCY(2),
        .XOR_MASK(32'hA5A5_0000)
    ) sub0_i (
        .clk(clk),
        .rst(rst),
        .araddr(m_araddr[0]),
        .arprot(m_arprot[0]),
        .arvalid(m_arvalid[0]),
        .arready(m_arready[0]),
        .rdata(m_rdata[0]),
        .rresp(m_rresp[0]),
        .rvalid(m_rvalid[0]),
        .rready(m_rready[0])
    );

    // Slow subordinate, the secure one
    axil_sub_model #(
        .LATENCY(7),
        .XOR_MASK(32'h5A5A_0000)
    ) sub1_i (
        .clk(clk),
        .rst(rst),
        .araddr(m_araddr[1]),
        .arprot(m_arprot[1]),
        .arvalid(m_arvalid[1]),
        .arready(m_arready[1]),
        .rdata(m_rdata[1]),
        .rresp(m_rresp[1]),
        .rvalid(m_rvalid[1]),
        .rready(m_rready[1])
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Subordinate port for an address, -1 outside both windows
    function automatic int target_port(input axil_xbar_pkg::addr_t addr);
        logic [32:0] a;
        a = {1'b0, addr};
        if (a >= {1'b0, `XBAR_SUB0_BASE}
                && a < {1'b0, `XBAR_SUB0_BASE} + (33'd1 << `XBAR_SUB0_ADDR_W)) begin
            return 0;
        end
        if (a >= {1'b0, `XBAR_SUB1_BASE}
                && a < {1'b0, `XBAR_SUB1_BASE} + (33'd1 << `XBAR_SUB1_ADDR_W)) begin
            return 1;
        end
        return -1;
    endfunction

    task automatic load_vectors();
        int base;
        for (int i = 0; i < MAX_VEC * FIELDS; i++) begin
            vec_mem[i] = '1;
        end
        $readmemh("test/axil_xbar_vectors.txt", vec_mem);
        vec_count = 0;
        while (vec_count < MAX_VEC && vec_mem[vec_count * FIELDS] != 32'hFFFF_FFFF) begin
            base = vec_count * FIELDS;
            vec_mgr[vec_count] = int'(vec_mem[base]);
            vec_addr[vec_count] = vec_mem[base + 1];
            vec_prot[vec_count] = vec_mem[base + 2][2:0];
            vec_resp[vec_count] = vec_mem[base + 3][1:0];
            vec_data[vec_count] = vec_mem[base + 4];
            vec_count++;
        end
    endtask

    task automatic drive_manager(input int m);
        int   gap;
        logic ready_now;
        for (int i = 0; i < vec_count; i++) begin
            if (vec_mgr[i] == m) begin
                random_bits(2, gap);
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                end
                s_araddr[m] = vec_addr[i];
                s_arprot[m] = vec_prot[i];
                s_arvalid[m] = 1'b1;
                ready_now = 1'b0;
                while (!ready_now) begin
                    ready_now = s_arready[m];
                    @(posedge clk);
                    #2;
                end
                s_arvalid[m] = 1'b0;
                exp_idx_q[m].push_back(i);
                if (vec_resp[i] == axil_xbar_pkg::RESP_OKAY) begin
                    pend_addr[m] = vec_addr[i];
                    pend_prot[m] = vec_prot[i];
                    pend_port[m] = target_port(vec_addr[i]);
                    passed_by[m] = 0;
                    pend_fwd[m] = 1'b1;
                end
            end
        end
    endtask

    initial begin : rready_driver
        int bits;
        s_rready = '0;
        forever begin
            @(posedge clk);
            #2;
            for (int m = 0; m < S; m++) begin
                random_bits(2, bits);
                s_rready[m] = bits != 0;
            end
        end
    end

    always @(posedge clk) begin : resp_monitor
        int idx;
        for (int m = 0; m < S; m++) begin
            if (!rst && s_rvalid[m] && s_rready[m]) begin
                if (exp_idx_q[m].size() == 0) begin
                    $display("ERROR: manager %0d got a response with no read outstanding", m);
                    errors++;
                end else begin
                    idx = exp_idx_q[m].pop_front();
                    resp_count[m]++;
                    if (s_rresp[m] !== vec_resp[idx] || s_rdata[m] !== vec_data[idx]) begin
                        $display("FAILED at %0t: manager %0d read %h got resp %0d data %h, %s %0d %h",
                                 $time, m, vec_addr[idx], s_rresp[m], s_rdata[m],
                                 "expected resp", vec_resp[idx], vec_data[idx]);
                        errors++;
                    end
                end
            end
        end
    end

    // Every forwarded read must belong to a waiting manager, with bounded overtaking
    always @(posedge clk) begin : ar_monitor
        logic matched;
        for (int n = 0; n < M; n++) begin
            if (!rst && m_arvalid[n] && m_arready[n]) begin
                fwd_count[n]++;
                matched = 1'b0;
                for (int m = 0; m < S; m++) begin
                    if (pend_fwd[m] && pend_port[m] == n) begin
                        if (!matched && pend_addr[m] == m_araddr[n]
                                && pend_prot[m] == m_arprot[n]) begin
                            pend_fwd[m] = 1'b0;
                            matched = 1'b1;
                        end else begin
                            passed_by[m]++;
                            if (passed_by[m] > 2) begin
                                $display("FAILED at %0t: manager %0d passed over %0d times at port %0d",
                                         $time, m, passed_by[m], n);
                                errors++;
                            end
                        end
                    end
                end
                if (!matched) begin
                    $display("FAILED at %0t: port %0d got read %h prot %0d that no manager issued",
                             $time, n, m_araddr[n], m_arprot[n]);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("ERROR: run stopped after %0d cycles with reads still outstanding",
                     cycle_count);
            errors++;
            $display("Checks done, %0d error(s)", errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        errors = 0;
        cycle_count = 0;
        lfsr_state = 32'h5186_7090;
        s_arvalid = '0;
        for (int m = 0; m < S; m++) begin
            s_araddr[m] = '0;
            s_arprot[m] = '0;
            resp_count[m] = 0;
            resp_expected[m] = 0;
            pend_fwd[m] = 1'b0;
            pend_addr[m] = '0;
            pend_prot[m] = '0;
            pend_port[m] = -1;
            passed_by[m] = 0;
        end
        for (int n = 0; n < M; n++) begin
            fwd_count[n] = 0;
            fwd_expected[n] = 0;
        end

        load_vectors();
        cycle_limit = 40 * vec_count + 200;
        for (int i = 0; i < vec_count; i++) begin
            resp_expected[vec_mgr[i]]++;
            if (vec_resp[i] == axil_xbar_pkg::RESP_OKAY && target_port(vec_addr[i]) >= 0) begin
                fwd_expected[target_port(vec_addr[i])]++;
            end
        end

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        fork
            drive_manager(0);
            drive_manager(1);
        join

        while (exp_idx_q[0].size() != 0 || exp_idx_q[1].size() != 0) begin
            @(posedge clk);
        end
        // Room for any stray response to show up
        repeat (10) @(posedge clk);

        for (int m = 0; m < S; m++) begin
            if (resp_count[m] != resp_expected[m]) begin
                $display("ERROR: manager %0d got %0d responses for %0d reads",
                         m, resp_count[m], resp_expected[m]);
                errors++;
            end
            if (pend_fwd[m]) begin
                $display("ERROR: read %h from manager %0d never reached a subordinate",
                         pend_addr[m], m);
                errors++;
            end
        end
        for (int n = 0; n < M; n++) begin
            if (fwd_count[n] != fwd_expected[n]) begin
                $display("FAILED at %0t: port %0d saw %0d reads, expected %0d",
                         $time, n, fwd_count[n], fwd_expected[n]);
                errors++;
            end
        end

        $display("Checks done, %0d error(s)", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- test/axil_xbar_vectors.txt
// Columns: manager, address, prot, expected rresp, expected rdata (all hex)
// prot bit 1 set is a non-secure read, rresp 3 is a decode error with zero data
0 00000010 0 0 A5A50010
0 0000FFFC 0 0 A5A5FFFC
0 00010020 0 0 5A5B0020
0 00010020 2 3 00000000
0 00020000 0 3 00000000
0 00010100 0 0 5A5B0100
0 00000100 0 0 A5A50100
0 00000200 0 0 A5A50200
0 00000204 0 0 A5A50204
0 00000208 0 0 A5A50208
0 0000020C 0 0 A5A5020C
0 80000000 0 3 00000000
1 00001000 0 0 A5A51000
1 00014000 0 0 5A5B4000
1 00014000 3 3 00000000
1 00014004 1 0 5A5B4004
1 FFFF0000 0 3 00000000
1 00003000 0 0 A5A53000
1 00003004 0 0 A5A53004
1 00003008 0 0 A5A53008
1 0000300C 0 0 A5A5300C
1 00010008 0 0 5A5B0008
1 00000008 2 0 A5A50008

//--- project.f
+incdir+common
common/axil_xbar_pkg.sv
common/axil_rd_if.sv
hw/axil_skid_reg.sv
crossbar/axil_addr_decode.sv
crossbar/rr_arbiter.sv
crossbar/axil_xbar_rd.sv
hw/axil_xbar_rd_top.sv
test/axil_sub_model.sv
test/tb_axil_xbar_rd.sv

//--- run_sim.sh
#!/bin/sh
# Builds the read crossbar testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_axil_xbar_rd \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
